// ==== design/apf_cfg_pkg.sv ====
/*
 * bridge I/O configuration package
 * widths, bridge address map, register offsets and save-slot constants
 */
package apf_cfg_pkg;

	localparam int bridge_addr_w = 32;
	localparam int bridge_data_w = 32;
	localparam int datatable_addr_w = 10;

	// top nibble of the bridge address
	typedef enum logic [3:0] {
		region_upload_p = 4'h1,
		region_upload_v = 4'h2,
		region_upload_c = 4'h4,
		region_cfg      = 4'hF
	} region_e;

	// low 16 bits of the address inside the config page
	typedef enum logic [15:0] {
		cfg_core_reset     = 16'h0100,
		cfg_dipsw          = 16'h0104,
		cfg_system_type    = 16'h0108,
		cfg_memcard_enable = 16'h010C,
		cfg_cpu_overclock  = 16'h0110,
		cfg_video_mode     = 16'h0200,
		cfg_ch_enable      = 16'h0300,
		cfg_snd_enable     = 16'h0304,
		cfg_pchip_main     = 16'h0404,
		cfg_pchip_sub      = 16'h0408
	} cfg_reg_e;

	typedef enum logic [1:0] {
		scan_address,
		scan_hold,
		scan_check,
		scan_update
	} scan_state_e;

	// data-slot ids and the save sizes reported for them
	localparam logic [31:0] memcard_slot_id = 32'h0000_0101;
	localparam logic [31:0] sram_slot_id = 32'h0000_0102;
	localparam logic [31:0] memcard_save_size = 32'd8192;
	localparam logic [31:0] sram_save_size = 32'd65536;

	localparam int datatable_last_entry = 127;

	// config page is 0xF000_xxxx
	function automatic logic in_cfg_page(input logic [bridge_addr_w-1:0] addr);
		return (addr[31:28] == region_cfg) && (addr[27:16] == 12'h000);
	endfunction

endpackage

// ==== design/apf_config_regs.sv ====
/*
 * configuration register file on the bridge config page
 * register writes, readback latch, protection-chip decode and restart request
 */
module apf_config_regs (
	input  logic                                  clk_74a,
	input  logic                                  reset_l_main,
	input  logic [apf_cfg_pkg::bridge_addr_w-1:0] bridge_addr,
	input  logic                                  bridge_wr,
	input  logic [apf_cfg_pkg::bridge_data_w-1:0] bridge_wr_data,
	input  logic                                  bridge_rd,
	output logic [apf_cfg_pkg::bridge_data_w-1:0] status_q,
	output logic                                  restart_req,
	output logic [7:0]                            dipsw,
	output logic                                  system_type,
	output logic [1:0]                            memory_card_enable,
	output logic                                  cpu_overclock,
	output logic                                  video_mode,
	output logic [5:0]                            ch_enable,
	output logic [3:0]                            snd_enable,
	output logic [2:0]                            cart_pchip
);
	import apf_cfg_pkg::*;

	cfg_reg_e   offset;
	logic       cfg_wr;
	logic       cfg_rd;
	logic       restart_hit;
	logic       core_reset_q;
	logic       pchip_main;
	logic [2:0] pchip_sub;

	assign offset = cfg_reg_e'(bridge_addr[15:0]);
	assign cfg_wr = bridge_wr && in_cfg_page(bridge_addr);
	assign cfg_rd = bridge_rd && in_cfg_page(bridge_addr);

	// system or clock change restarts the core, core_reset only with bit 0
	assign restart_hit = cfg_wr && ((offset == cfg_system_type) ||
		(offset == cfg_cpu_overclock) ||
		((offset == cfg_core_reset) && bridge_wr_data[0]));

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			core_reset_q <= 1'b0;
			dipsw <= 8'hFF;
			system_type <= 1'b1;
			memory_card_enable <= 2'b00;
			cpu_overclock <= 1'b0;
			video_mode <= 1'b0;
			ch_enable <= 6'h3F;
			snd_enable <= 4'hF;
			pchip_main <= 1'b0;
			pchip_sub <= 3'd0;
			restart_req <= 1'b0;
		end else begin
			// request follows the restart write strobe by one cycle
			restart_req <= restart_hit;
			if (cfg_wr) begin
				case (offset)
					cfg_core_reset:     core_reset_q <= bridge_wr_data[0];
					cfg_dipsw:          dipsw <= bridge_wr_data[7:0];
					cfg_system_type:    system_type <= bridge_wr_data[0];
					cfg_memcard_enable: memory_card_enable <= bridge_wr_data[1:0];
					cfg_cpu_overclock:  cpu_overclock <= bridge_wr_data[0];
					cfg_video_mode:     video_mode <= bridge_wr_data[0];
					cfg_ch_enable:      ch_enable <= bridge_wr_data[5:0];
					cfg_snd_enable:     snd_enable <= bridge_wr_data[3:0];
					cfg_pchip_main:     pchip_main <= bridge_wr_data[0];
					cfg_pchip_sub:      pchip_sub <= bridge_wr_data[2:0];
					default: ;
				endcase
			end
		end
	end

	// readback latch, valid the cycle after the read strobe
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			status_q <= '0;
		end else if (cfg_rd) begin
			case (offset)
				cfg_core_reset:     status_q <= bridge_data_w'(core_reset_q);
				cfg_dipsw:          status_q <= bridge_data_w'(dipsw);
				cfg_system_type:    status_q <= bridge_data_w'(system_type);
				cfg_memcard_enable: status_q <= bridge_data_w'(memory_card_enable);
				cfg_cpu_overclock:  status_q <= bridge_data_w'(cpu_overclock);
				cfg_video_mode:     status_q <= bridge_data_w'(video_mode);
				cfg_ch_enable:      status_q <= bridge_data_w'(ch_enable);
				cfg_snd_enable:     status_q <= bridge_data_w'(snd_enable);
				cfg_pchip_main:     status_q <= bridge_data_w'(pchip_main);
				cfg_pchip_sub:      status_q <= bridge_data_w'(pchip_sub);
				default:            status_q <= '0;
			endcase
		end
	end

	// protection chip select
	// main chip wins, sub values 1..5 map to 3..7
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cart_pchip <= 3'd0;
		end else if (pchip_main) begin
			cart_pchip <= 3'd2;
		end else if ((pchip_sub >= 3'd1) && (pchip_sub <= 3'd5)) begin
			cart_pchip <= pchip_sub + 3'd2;
		end else begin
			cart_pchip <= 3'd0;
		end
	end

	// the restart timer must see exactly one load per request
	restart_req_single: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		restart_req |=> !restart_req
	) else $error("restart_req held for more than one cycle");

endmodule

// ==== design/rom_mask_tracker.sv ====
/*
 * ROM size mask tracker
 * watches asset upload writes and builds thermometer masks per ROM
 */
module rom_mask_tracker (
	input  logic                                  clk_74a,
	input  logic                                  reset_l_main,
	input  logic [apf_cfg_pkg::bridge_addr_w-1:0] bridge_addr,
	input  logic                                  bridge_wr,
	output logic [23:0]                           p2rom_mask,
	output logic [18:0]                           mrom_mask,
	output logic [18:0]                           srom_mask,
	output logic [23:0]                           v1rom_mask,
	output logic [25:0]                           crom_mask
);
	import apf_cfg_pkg::*;

	logic [bridge_addr_w-1:0] addr_q;
	logic                     wr_q;
	logic                     prom1;
	logic [25:0]              fill_p;
	logic [25:0]              fill_ms;
	logic [25:0]              fill_v;
	logic [25:0]              fill_c;
	logic                     band_prom;
	logic                     band_p;
	logic                     band_s;
	logic                     band_m;
	logic                     band_v;
	logic                     band_c;

	// bit i set when any bit at or above i is set
	function automatic logic [25:0] fill_bits(input logic [25:0] v);
		logic [25:0] f;
		f[25] = v[25];
		for (int i = 24; i >= 0; i--) begin
			f[i] = f[i + 1] | v[i];
		end
		return f;
	endfunction

	function automatic logic is_therm(input logic [25:0] m);
		return (m & (m + 26'd1)) == 26'd0;
	endfunction

	// address registered first, masks follow a cycle later
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= bridge_wr;
		end
	end

	always_ff @(posedge clk_74a) begin
		if (bridge_wr) begin
			addr_q <= bridge_addr;
		end
	end

	assign fill_p = fill_bits({3'b000, addr_q[22:0]});
	assign fill_ms = fill_bits({7'd0, addr_q[18:0]});
	assign fill_v = fill_bits({2'b00, addr_q[23:0]});
	assign fill_c = fill_bits({16'd0, addr_q[25:16]});

	// 0x10xx_xxxx program/fix/music uploads
	assign band_prom = (addr_q[31:28] == region_upload_p) && (addr_q[27:24] == 4'h0);
	assign band_p = band_prom && !addr_q[23];
	assign band_s = band_prom && (addr_q[23:20] == 4'hC);
	assign band_m = band_prom && (addr_q[23:19] == 5'b11111);
	assign band_v = (addr_q[31:28] == region_upload_v) && (addr_q[27:24] == 4'h0);
	assign band_c = (addr_q[31:28] == region_upload_c);

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			prom1 <= 1'b0;
			p2rom_mask <= '0;
			mrom_mask <= '0;
			srom_mask <= '0;
			v1rom_mask <= '0;
			crom_mask <= '0;
		end else if (wr_q) begin
			// P2 mask takes the flag as it stood before this write
			if (band_prom) begin
				if (addr_q[23:20] == 4'h8) begin
					prom1 <= 1'b1;
				end else if (!addr_q[23]) begin
					prom1 <= 1'b0;
				end
			end
			if (band_p) begin
				p2rom_mask <= {prom1, fill_p[22:0]};
			end
			if (band_s) begin
				srom_mask <= fill_ms[18:0];
			end
			if (band_m) begin
				mrom_mask <= fill_ms[18:0];
			end
			if (band_v) begin
				v1rom_mask <= fill_v[23:0];
			end
			// C ROM granularity is 64 KiB
			if (band_c) begin
				crom_mask <= {fill_c[9:0], 16'hFFFF};
			end
		end
	end

	// P2 top bit is the prom1 flag and not part of the fill
	masks_thermometer: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		is_therm({3'b000, p2rom_mask[22:0]}) && is_therm({7'd0, mrom_mask}) &&
		is_therm({7'd0, srom_mask}) && is_therm({2'b00, v1rom_mask}) &&
		is_therm(crom_mask)
	) else $error("ROM mask is not a thermometer code");

endmodule

// ==== design/core_reset_timer.sv ====
/*
 * core restart timer
 * holds start_system low for restart_hold cycles after a restart request
 */
module core_reset_timer #(
	parameter int restart_hold = (1 << 26) - 1
) (
	input  logic clk_74a,
	input  logic reset_l_main,
	input  logic restart_req,
	input  logic dataslot_allcomplete,
	output logic start_system
);

	localparam int cnt_w = $clog2(restart_hold + 1);

	logic [cnt_w-1:0] count;

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			count <= '0;
			start_system <= 1'b0;
		end else begin
			// reload on request, otherwise count down and park at zero
			if (restart_req) begin
				count <= cnt_w'(restart_hold);
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
			start_system <= (count == '0) && dataslot_allcomplete;
		end
	end

	// load lands one cycle after the request, start drops one after that
	start_low_after_load: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		restart_req |-> ##2 !start_system
	) else $error("start_system high right after a restart load");

endmodule

// ==== design/save_slot_scanner.sv ====
/*
 * save slot scanner
 * walks the data-slot table and writes memory card and backup RAM sizes
 */
module save_slot_scanner (
	input  logic                                     clk_74a,
	input  logic                                     reset_l_main,
	input  logic [31:0]                              datatable_q,
	output logic [apf_cfg_pkg::datatable_addr_w-1:0] datatable_addr,
	output logic                                     datatable_wren,
	output logic [31:0]                              datatable_data
);
	import apf_cfg_pkg::*;

	scan_state_e                 state;
	logic [datatable_addr_w-1:0] step_addr;
	logic [datatable_addr_w-1:0] next_even;
	logic                        id_match;

	// next even entry, wrapping past the last table entry
	assign step_addr = {datatable_addr[datatable_addr_w-1:1] + 1'b1, 1'b0};
	assign next_even = (step_addr > datatable_addr_w'(datatable_last_entry)) ? '0 : step_addr;
	assign id_match = (datatable_q == memcard_slot_id) || (datatable_q == sram_slot_id);

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			state <= scan_address;
			datatable_addr <= '0;
			datatable_wren <= 1'b0;
		end else begin
			datatable_wren <= 1'b0;
			case (state)
				scan_address: state <= scan_hold;
				// table read data lands here
				scan_hold: state <= scan_check;
				scan_check: begin
					if (id_match) begin
						// size goes in the odd entry next to the id
						datatable_addr <= {datatable_addr[datatable_addr_w-1:1], 1'b1};
						datatable_wren <= 1'b1;
						state <= scan_update;
					end else begin
						datatable_addr <= next_even;
						state <= scan_address;
					end
				end
				scan_update: begin
					datatable_addr <= next_even;
					state <= scan_address;
				end
				default: state <= scan_address;
			endcase
		end
	end

	always_ff @(posedge clk_74a) begin
		if ((state == scan_check) && id_match) begin
			datatable_data <= (datatable_q == memcard_slot_id) ? memcard_save_size :
				sram_save_size;
		end
	end

	// size writes are single pulses into the odd entry
	wren_odd_pulse: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		datatable_wren |-> datatable_addr[0] ##1 !datatable_wren
	) else $error("datatable write to even entry or longer than one cycle");

endmodule

// ==== design/apf_io_top.sv ====
/*
 * bridge I/O configuration and monitoring top
 * config registers, ROM masks, restart timer, save scanner and read mux
 */
module apf_io_top #(
	parameter int restart_hold = (1 << 26) - 1
) (
	input  logic                                     clk_74a,
	input  logic                                     reset_l_main,
	input  logic [apf_cfg_pkg::bridge_addr_w-1:0]    bridge_addr,
	input  logic                                     bridge_wr,
	input  logic [apf_cfg_pkg::bridge_data_w-1:0]    bridge_wr_data,
	input  logic                                     bridge_rd,
	input  logic [apf_cfg_pkg::bridge_data_w-1:0]    cmd_rd_data,
	input  logic                                     dataslot_allcomplete,
	input  logic [31:0]                              datatable_q,
	output logic [apf_cfg_pkg::bridge_data_w-1:0]    bridge_rd_data,
	output logic [apf_cfg_pkg::datatable_addr_w-1:0] datatable_addr,
	output logic                                     datatable_wren,
	output logic [31:0]                              datatable_data,
	output logic                                     start_system,
	output logic [7:0]                               dipsw,
	output logic                                     system_type,
	output logic [1:0]                               memory_card_enable,
	output logic                                     cpu_overclock,
	output logic                                     video_mode,
	output logic [5:0]                               ch_enable,
	output logic [3:0]                               snd_enable,
	output logic [2:0]                               cart_pchip,
	output logic [23:0]                              p2rom_mask,
	output logic [18:0]                              mrom_mask,
	output logic [18:0]                              srom_mask,
	output logic [23:0]                              v1rom_mask,
	output logic [25:0]                              crom_mask
);
	import apf_cfg_pkg::*;

	logic [bridge_data_w-1:0] status_q;
	logic                     restart_req;

	apf_config_regs config_regs_i (
		.clk_74a            (clk_74a),
		.reset_l_main       (reset_l_main),
		.bridge_addr        (bridge_addr),
		.bridge_wr          (bridge_wr),
		.bridge_wr_data     (bridge_wr_data),
		.bridge_rd          (bridge_rd),
		.status_q           (status_q),
		.restart_req        (restart_req),
		.dipsw              (dipsw),
		.system_type        (system_type),
		.memory_card_enable (memory_card_enable),
		.cpu_overclock      (cpu_overclock),
		.video_mode         (video_mode),
		.ch_enable          (ch_enable),
		.snd_enable         (snd_enable),
		.cart_pchip         (cart_pchip)
	);

	rom_mask_tracker rom_mask_tracker_i (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.bridge_addr  (bridge_addr),
		.bridge_wr    (bridge_wr),
		.p2rom_mask   (p2rom_mask),
		.mrom_mask    (mrom_mask),
		.srom_mask    (srom_mask),
		.v1rom_mask   (v1rom_mask),
		.crom_mask    (crom_mask)
	);

	core_reset_timer #(
		.restart_hold (restart_hold)
	) core_reset_timer_i (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.restart_req          (restart_req),
		.dataslot_allcomplete (dataslot_allcomplete),
		.start_system         (start_system)
	);

	save_slot_scanner save_slot_scanner_i (
		.clk_74a        (clk_74a),
		.reset_l_main   (reset_l_main),
		.datatable_q    (datatable_q),
		.datatable_addr (datatable_addr),
		.datatable_wren (datatable_wren),
		.datatable_data (datatable_data)
	);

	// config page reads come from the latch, everything else from the command block
	assign bridge_rd_data = in_cfg_page(bridge_addr) ? status_q : cmd_rd_data;

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * testbench clock source, period of 4 time units
 */
module tb_clock #(
	parameter int half_period = 2
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #half_period clk = ~clk;

endmodule

// ==== testbench/apf_io_tb.sv ====
/*
 * testbench for the bridge I/O configuration top
 * register readback, pchip decode, ROM masks, restart timing and save scanner
 */
module apf_io_tb;
	import apf_cfg_pkg::*;

	// all tests take well under a thousand cycles, scanner wraps twice in about 400
	localparam int run_cycles = 4000;
	localparam int hold = 40;
	// one full table pass, three cycles per even entry and one more per size write
	localparam int scan_pass = 64 * 3 + 2;

	logic        clk_74a;
	logic        reset_l_main;
	logic [31:0] bridge_addr;
	logic        bridge_wr;
	logic [31:0] bridge_wr_data;
	logic        bridge_rd;
	logic [31:0] cmd_rd_data;
	logic        dataslot_allcomplete;
	logic [31:0] datatable_q;
	logic [31:0] bridge_rd_data;
	logic [9:0]  datatable_addr;
	logic        datatable_wren;
	logic [31:0] datatable_data;
	logic        start_system;
	logic [7:0]  dipsw;
	logic        system_type;
	logic [1:0]  memory_card_enable;
	logic        cpu_overclock;
	logic        video_mode;
	logic [5:0]  ch_enable;
	logic [3:0]  snd_enable;
	logic [2:0]  cart_pchip;
	logic [23:0] p2rom_mask;
	logic [18:0] mrom_mask;
	logic [18:0] srom_mask;
	logic [23:0] v1rom_mask;
	logic [25:0] crom_mask;

	// checker state driven by the stimulus
	logic        chk_rd;
	logic [31:0] exp_rd;
	logic        chk_state;
	logic [2:0]  exp_pchip;
	logic [23:0] exp_p2;
	logic [18:0] exp_m;
	logic [18:0] exp_s;
	logic [23:0] exp_v1;
	logic [25:0] exp_c;
	logic        prom1_m;
	logic        restart_go;
	logic        restart_win;
	int          since_write;
	logic        chk_scan;
	int          wr5_cnt;
	int          wr11_cnt;
	int          wr5_base;
	int          wr11_base;
	logic [31:0] table_mem [128];
	logic [15:0] offsets [10];
	logic [31:0] exp_regs [10];
	logic        exp_main;
	logic [2:0]  exp_sub;
	integer      seed;

	tb_clock clock_i (.clk(clk_74a));

	apf_io_top #(.restart_hold(hold)) apf_io_top_i (.*);

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string msg);
		$display("Mismatch at time %0t: %s", $time, msg);
		fail_stop("check failed");
	endtask

	function automatic int reg_width(input logic [15:0] off);
		case (off)
			16'h0104: return 8;
			16'h010C: return 2;
			16'h0300: return 6;
			16'h0304: return 4;
			16'h0408: return 3;
			default:  return 1;
		endcase
	endfunction

	function automatic logic [31:0] reg_default(input logic [15:0] off);
		case (off)
			16'h0104: return 32'hFF;
			16'h0108: return 32'h1;
			16'h0300: return 32'h3F;
			16'h0304: return 32'hF;
			default:  return 32'h0;
		endcase
	endfunction

	// bit i set when v has any bit at or above i
	function automatic logic [25:0] fill_down(input logic [25:0] v);
		logic [25:0] f;
		for (int i = 0; i < 26; i++) begin
			f[i] = (v >> i) != 26'd0;
		end
		return f;
	endfunction

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_wr_data <= data;
		bridge_wr <= 1'b1;
		@(posedge clk_74a);
		bridge_wr <= 1'b0;
	endtask

	task automatic read_check(input logic [31:0] addr, input logic [31:0] expected);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_rd <= 1'b1;
		@(posedge clk_74a);
		bridge_rd <= 1'b0;
		exp_rd <= expected;
		chk_rd <= 1'b1;
		@(posedge clk_74a);
		chk_rd <= 1'b0;
	endtask

	// outputs settle two cycles after the write strobe
	task automatic state_check();
		@(posedge clk_74a);
		chk_state <= 1'b1;
		@(posedge clk_74a);
		chk_state <= 1'b0;
	endtask

	task automatic upload_check(input logic [31:0] addr);
		if (addr[31:24] == 8'h10) begin
			if (!addr[23]) begin
				exp_p2 = {prom1_m, 23'(fill_down({3'd0, addr[22:0]}))};
			end
			if (addr[23:20] == 4'hC) begin
				exp_s = 19'(fill_down({7'd0, addr[18:0]}));
			end
			if (addr[23:16] >= 8'hF8) begin
				exp_m = 19'(fill_down({7'd0, addr[18:0]}));
			end
			if (addr[23:20] == 4'h8) begin
				prom1_m = 1'b1;
			end else if (addr < 32'h1080_0000) begin
				prom1_m = 1'b0;
			end
		end
		if (addr[31:24] == 8'h20) begin
			exp_v1 = 24'(fill_down({2'd0, addr[23:0]}));
		end
		if (addr[31:28] == 4'h4) begin
			exp_c = {10'(fill_down({16'd0, addr[25:16]})), 16'hFFFF};
		end
		bus_write(addr, $random(seed));
		state_check();
	endtask

	task automatic restart_check(input logic [15:0] off, input logic [31:0] data,
		input logic allcomplete);
		@(posedge clk_74a);
		dataslot_allcomplete <= allcomplete;
		@(posedge clk_74a);
		bridge_addr <= {16'hF000, off};
		bridge_wr_data <= data;
		bridge_wr <= 1'b1;
		restart_go <= 1'b1;
		restart_win <= 1'b1;
		@(posedge clk_74a);
		bridge_wr <= 1'b0;
		restart_go <= 1'b0;
		repeat (60) @(posedge clk_74a);
		restart_win <= 1'b0;
		dataslot_allcomplete <= 1'b1;
	endtask

	// data table with one cycle read latency
	always @(posedge clk_74a) begin
		datatable_q <= table_mem[datatable_addr[6:0]];
		if (datatable_wren) begin
			table_mem[datatable_addr[6:0]] <= datatable_data;
		end
	end

	always @(posedge clk_74a) begin
		if (datatable_wren && datatable_addr == 10'd5) begin
			wr5_cnt <= wr5_cnt + 1;
		end
		if (datatable_wren && datatable_addr == 10'd11) begin
			wr11_cnt <= wr11_cnt + 1;
		end
		if (restart_go) begin
			since_write <= 0;
		end else begin
			since_write <= since_write + 1;
		end
	end

	readback_value: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		chk_rd |-> bridge_rd_data == exp_rd
	) else mismatch($sformatf("read data %h, expected %h", bridge_rd_data, exp_rd));

	// exp_regs follows the offsets list, entry 0 and the pchip pair have no port
	reg_outputs: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		chk_rd |-> (dipsw == exp_regs[1][7:0]) &&
			(system_type == exp_regs[2][0]) &&
			(memory_card_enable == exp_regs[3][1:0]) &&
			(cpu_overclock == exp_regs[4][0]) &&
			(video_mode == exp_regs[5][0]) &&
			(ch_enable == exp_regs[6][5:0]) &&
			(snd_enable == exp_regs[7][3:0])
	) else mismatch("config register output differs from the last write");

	pchip_decode: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		chk_state |-> cart_pchip == exp_pchip
	) else mismatch($sformatf("cart_pchip %0d, expected %0d", cart_pchip, exp_pchip));

	mask_values: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		chk_state |-> (p2rom_mask == exp_p2) && (mrom_mask == exp_m) &&
			(srom_mask == exp_s) && (v1rom_mask == exp_v1) && (crom_mask == exp_c)
	) else mismatch("ROM mask differs from the fill of the upload address");

	// write sampled with since_write stale, so the count lags by two
	restart_hold_low: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		(restart_win && since_write >= 2 && since_write <= 41) |-> !start_system
	) else mismatch("start_system high inside the restart hold");

	restart_release: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		(restart_win && dataslot_allcomplete && since_write == 44) |-> start_system
	) else mismatch("start_system did not rise after the restart hold");

	start_needs_slots: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		!dataslot_allcomplete |=> !start_system
	) else mismatch("start_system high while data slots incomplete");

	scan_write_target: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		datatable_wren |-> (datatable_addr == 10'd5 && datatable_data == 32'd8192) ||
			(datatable_addr == 10'd11 && datatable_data == 32'd65536)
	) else mismatch($sformatf("table write %h to entry %0d", datatable_data, datatable_addr));

	// any window of one full pass holds exactly one write to each size entry
	scan_repeats: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		chk_scan |-> (wr5_base > 0) && (wr11_base > 0) &&
			(wr5_cnt == wr5_base + 1) && (wr11_cnt == wr11_base + 1)
	) else mismatch($sformatf("%0d and %0d size writes in one scan pass",
		wr5_cnt - wr5_base, wr11_cnt - wr11_base));

	initial begin
		repeat (run_cycles) @(posedge clk_74a);
		fail_stop("Timeout: run did not finish in time");
	end

	initial begin
		logic [31:0] r;
		seed = 32'h261f;
		reset_l_main = 1'b0;
		bridge_addr = '0;
		bridge_wr = 1'b0;
		bridge_wr_data = '0;
		bridge_rd = 1'b0;
		cmd_rd_data = '0;
		dataslot_allcomplete = 1'b1;
		datatable_q = '0;
		chk_rd = 1'b0;
		exp_rd = '0;
		chk_state = 1'b0;
		restart_go = 1'b0;
		restart_win = 1'b0;
		since_write = 1000;
		chk_scan = 1'b0;
		wr5_cnt = 0;
		wr11_cnt = 0;
		wr5_base = 0;
		wr11_base = 0;
		prom1_m = 1'b0;
		exp_p2 = '0;
		exp_m = '0;
		exp_s = '0;
		exp_v1 = '0;
		exp_c = '0;
		exp_main = 1'b0;
		exp_sub = '0;
		exp_pchip = '0;
		for (int i = 0; i < 128; i++) begin
			table_mem[i] = 32'hC0DE_0000 | i;
		end
		table_mem[4] = 32'h101;
		table_mem[10] = 32'h102;
		offsets = '{16'h0100, 16'h0104, 16'h0108, 16'h010C, 16'h0110,
			16'h0200, 16'h0300, 16'h0304, 16'h0404, 16'h0408};
		for (int i = 0; i < 10; i++) begin
			exp_regs[i] = reg_default(offsets[i]);
		end
		repeat (8) @(posedge clk_74a);
		reset_l_main <= 1'b1;

		for (int i = 0; i < 10; i++) begin
			read_check({16'hF000, offsets[i]}, exp_regs[i]);
		end
		for (int i = 0; i < 10; i++) begin
			r = $random(seed);
			exp_regs[i] = r & ((32'd1 << reg_width(offsets[i])) - 1);
			bus_write({16'hF000, offsets[i]}, r);
			read_check({16'hF000, offsets[i]}, exp_regs[i]);
		end
		@(posedge clk_74a);
		cmd_rd_data <= $random(seed);
		@(posedge clk_74a);
		read_check({16'h3000, 16'(seed)}, cmd_rd_data);

		// pchip main is written every other pass so the sub decode is reached
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			exp_main = r[0] & i[0];
			exp_sub = r[6:4];
			exp_pchip = exp_main ? 3'd2 :
				((exp_sub >= 3'd1 && exp_sub <= 3'd5) ? exp_sub + 3'd2 : 3'd0);
			bus_write(32'hF000_0404, {r[31:1], exp_main});
			bus_write(32'hF000_0408, r >> 4);
			state_check();
		end

		for (int i = 0; i < 4; i++) begin
			upload_check({8'h10, 1'b0, 23'($random(seed))});
			upload_check({12'h108, 20'($random(seed))});
			upload_check({8'h10, 1'b0, 23'($random(seed))});
			upload_check({12'h10C, 20'($random(seed))});
			upload_check({13'b0001_0000_1111_1, 19'($random(seed))});
			upload_check({8'h20, 24'($random(seed))});
			upload_check({4'h4, 28'($random(seed))});
		end

		restart_check(cfg_system_type, 32'h1, 1'b1);
		restart_check(cfg_cpu_overclock, $random(seed), 1'b1);
		restart_check(cfg_core_reset, $random(seed) | 32'h1, 1'b1);
		restart_check(cfg_system_type, 32'h0, 1'b0);

		// counts taken before this edge's update, the check covers one pass of edges
		wr5_base = wr5_cnt;
		wr11_base = wr11_cnt;
		repeat (scan_pass - 1) @(posedge clk_74a);
		chk_scan <= 1'b1;
		@(posedge clk_74a);
		chk_scan <= 1'b0;
		@(posedge clk_74a);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== build.f ====
design/apf_cfg_pkg.sv
design/apf_config_regs.sv
design/rom_mask_tracker.sv
design/core_reset_timer.sv
design/save_slot_scanner.sv
design/apf_io_top.sv
testbench/tb_clock.sv
testbench/apf_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the apf_io regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f build.f \
	--top-module apf_io_tb -Mdir obj_dir -o apf_io_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/apf_io_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
